// ==== hw/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`define XLEN             32
`define REG_ADDR_W       5

// Base opcodes
`define OP_LUI           7'b0110111
`define OP_AUIPC         7'b0010111
`define OP_JAL           7'b1101111
`define OP_JALR          7'b1100111
`define OP_BRANCH        7'b1100011
`define OP_LOAD          7'b0000011
`define OP_STORE         7'b0100011
`define OP_IMM           7'b0010011
`define OP_REG           7'b0110011

// Branch conditions by funct3
`define F3_BEQ           3'b000
`define F3_BNE           3'b001
`define F3_BLT           3'b100
`define F3_BGE           3'b101
`define F3_BLTU          3'b110
`define F3_BGEU          3'b111

`define DMEM_WORDS       256
`define UART_TX_ADDR     32'h0001_0000
`define UART_STATUS_ADDR 32'h0001_0004
`define RESET_PC         32'h0000_0000
`define NOP_INSTR        32'h0000_0013

`endif

// ==== hw/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_e;
    typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        src_a_e  src_a;
        src_b_e  src_b;
        wb_sel_e wb_sel;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    jalr;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  pc_plus_4;
        logic [31:0]       instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            instr;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       pc_plus_4;
        ctrl_t                  ctrl;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            instr;
        logic [`XLEN-1:0]       pc_plus_4;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        wb_sel_e                wb_sel;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
    } ex_mem_t;

    // Write-back value is resolved in the memory stage
    typedef struct packed {
        logic                   valid;
        logic [31:0]            instr;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       wb_data;
    } mem_wb_t;

    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } uart_tx_t;

endpackage

`default_nettype wire

// ==== hw/stage_reg.sv ====
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic stall,
    input  wire logic flush,
    input  payload_t  d,
    output payload_t  q
);

    // Flush has priority over stall, loading a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_fetch.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_fetch import rv_core_pkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             stall,
    input  wire logic             redirect,
    input  wire logic [`XLEN-1:0] redirect_pc,
    output logic      [`XLEN-1:0] imem_addr,
    input  wire logic [`XLEN-1:0] imem_data,
    output if_id_t                if_out
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus_4;

    assign pc_plus_4 = pc + `XLEN'd4;
    assign imem_addr = pc;

    // Redirect beats a load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus_4;
        end
    end

    always_comb begin
        if_out.valid     = 1'b1;
        if_out.pc        = pc;
        if_out.pc_plus_4 = pc_plus_4;
        if_out.instr     = imem_data;
    end

endmodule

`default_nettype wire

// ==== hw/rv_decode.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_decode import rv_core_pkg::*; (
    input  if_id_t                      if_in,
    input  wire logic [`XLEN-1:0]       rs1_data,
    input  wire logic [`XLEN-1:0]       rs2_data,
    output logic      [`REG_ADDR_W-1:0] rs1_addr,
    output logic      [`REG_ADDR_W-1:0] rs2_addr,
    output id_ex_t                      id_out
);

    logic [31:0]      instr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             f7_b5;
    logic [`XLEN-1:0] imm;
    ctrl_t            ctrl;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr    = if_in.instr;
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign f7_b5    = instr[30];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediate formats
    always_comb begin
        case (opcode)
            `OP_STORE:         imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `OP_BRANCH:        imm = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            `OP_LUI, `OP_AUIPC: imm = {instr[31:12], 12'b0};
            `OP_JAL:           imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
            default:           imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            `OP_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.src_b     = SRC_B_IMM;
                ctrl.reg_write = 1'b1;
            end
            `OP_AUIPC: begin
                ctrl.src_a     = SRC_A_PC;
                ctrl.src_b     = SRC_B_IMM;
                ctrl.reg_write = 1'b1;
            end
            `OP_JAL, `OP_JALR: begin
                ctrl.src_a     = (opcode == `OP_JAL) ? SRC_A_PC : SRC_A_REG;
                ctrl.src_b     = SRC_B_IMM;
                ctrl.wb_sel    = WB_PC4;
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = (opcode == `OP_JALR);
            end
            `OP_BRANCH: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.branch = 1'b1;
            end
            `OP_LOAD: begin
                ctrl.src_b     = SRC_B_IMM;
                ctrl.wb_sel    = WB_LOAD;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            `OP_STORE: begin
                ctrl.src_b     = SRC_B_IMM;
                ctrl.mem_write = 1'b1;
            end
            `OP_IMM: begin
                // Only SRAI uses the funct7 bit
                ctrl.alu_op    = alu_from_funct3(funct3, f7_b5 && funct3 == 3'b101);
                ctrl.src_b     = SRC_B_IMM;
                ctrl.reg_write = 1'b1;
            end
            `OP_REG: begin
                ctrl.alu_op    = alu_from_funct3(funct3, f7_b5);
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        id_out = '0;
        if (if_in.valid) begin
            id_out.valid     = 1'b1;
            id_out.instr     = instr;
            id_out.pc        = if_in.pc;
            id_out.pc_plus_4 = if_in.pc_plus_4;
            id_out.ctrl      = ctrl;
            id_out.funct3    = funct3;
            id_out.rs1       = rs1_addr;
            id_out.rs2       = rs2_addr;
            id_out.rd        = instr[11:7];
            id_out.rs1_data  = rs1_data;
            id_out.rs2_data  = rs2_data;
            id_out.imm       = imm;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_regfile import rv_core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic [`REG_ADDR_W-1:0] rs1_addr,
    input  wire logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic      [`XLEN-1:0]       rs1_data,
    output logic      [`XLEN-1:0]       rs2_data,
    input  mem_wb_t                     wb
);

    logic [`XLEN-1:0] regs [1:31];
    logic             wr_en;

    assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.wb_data;
        end
    end

    // x0 is hardwired, WB write bypasses to the read side
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != '0) begin
            rs1_data = (wr_en && wb.rd == rs1_addr) ? wb.wb_data : regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_data = (wr_en && wb.rd == rs2_addr) ? wb.wb_data : regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_hazard.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_hazard import rv_core_pkg::*; (
    input  id_ex_t    id_in,
    input  id_ex_t    ex_in,
    input  ex_mem_t   mem_in,
    input  mem_wb_t   wb_in,
    input  wire logic redirect,
    output logic      stall_fetch,
    output logic      stall_decode,
    output logic      flush_decode,
    output logic      flush_execute,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output fwd_sel_e  fwd_store
);

    logic load_use;

    // MEM is younger than WB so it is checked first
    function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] rs, input logic used);
        if (!used || rs == '0) begin
            return FWD_NONE;
        end
        if (mem_in.valid && mem_in.reg_write && mem_in.rd == rs) begin
            return FWD_MEM;
        end
        if (wb_in.valid && wb_in.reg_write && wb_in.rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a     = pick_src(ex_in.rs1, ex_in.ctrl.src_a == SRC_A_REG);
    assign fwd_b     = pick_src(ex_in.rs2, ex_in.ctrl.src_b == SRC_B_REG);
    assign fwd_store = pick_src(ex_in.rs2, ex_in.ctrl.mem_write);

    assign load_use = ex_in.valid && ex_in.ctrl.mem_read && ex_in.rd != '0 && id_in.valid
                      && (ex_in.rd == id_in.rs1 || ex_in.rd == id_in.rs2);

    assign stall_fetch   = load_use;
    assign stall_decode  = load_use;
    assign flush_decode  = redirect;
    assign flush_execute = redirect || load_use;

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_execute import rv_core_pkg::*; (
    input  id_ex_t                ex_in,
    input  fwd_sel_e              fwd_a,
    input  fwd_sel_e              fwd_b,
    input  fwd_sel_e              fwd_store,
    input  wire logic [`XLEN-1:0] mem_fwd,
    input  wire logic [`XLEN-1:0] wb_fwd,
    output ex_mem_t               ex_out,
    output logic                  redirect,
    output logic      [`XLEN-1:0] redirect_pc
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] store_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;
    logic             take_branch;

    function automatic logic [`XLEN-1:0] pick_operand(input fwd_sel_e sel,
                                                      input logic [`XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return mem_fwd;
            FWD_WB:  return wb_fwd;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_val   = pick_operand(fwd_a, ex_in.rs1_data);
    assign rs2_val   = pick_operand(fwd_b, ex_in.rs2_data);
    assign store_val = pick_operand(fwd_store, ex_in.rs2_data);

    assign op_a  = (ex_in.ctrl.src_a == SRC_A_PC) ? ex_in.pc : rs1_val;
    assign op_b  = (ex_in.ctrl.src_b == SRC_B_IMM) ? ex_in.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_in.ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // Equality reuses the ALU subtraction
    always_comb begin
        case (ex_in.funct3)
            `F3_BEQ:  take_branch = (alu_result == '0);
            `F3_BNE:  take_branch = (alu_result != '0);
            `F3_BLT:  take_branch = ($signed(rs1_val) < $signed(rs2_val));
            `F3_BGE:  take_branch = ($signed(rs1_val) >= $signed(rs2_val));
            `F3_BLTU: take_branch = (rs1_val < rs2_val);
            `F3_BGEU: take_branch = (rs1_val >= rs2_val);
            default:  take_branch = 1'b0;
        endcase
    end

    assign redirect = ex_in.valid
                      && (ex_in.ctrl.jump || (ex_in.ctrl.branch && take_branch));

    // JALR clears bit 0 of its target
    always_comb begin
        redirect_pc = ex_in.pc + ex_in.imm;
        if (ex_in.ctrl.jump) begin
            redirect_pc = alu_result;
            if (ex_in.ctrl.jalr) begin
                redirect_pc[0] = 1'b0;
            end
        end
    end

    always_comb begin
        ex_out            = '0;
        ex_out.valid      = ex_in.valid;
        ex_out.instr      = ex_in.instr;
        ex_out.pc_plus_4  = ex_in.pc_plus_4;
        ex_out.reg_write  = ex_in.ctrl.reg_write;
        ex_out.mem_read   = ex_in.ctrl.mem_read;
        ex_out.mem_write  = ex_in.ctrl.mem_write;
        ex_out.wb_sel     = ex_in.ctrl.wb_sel;
        ex_out.rd         = ex_in.rd;
        ex_out.alu_result = alu_result;
        ex_out.store_data = store_val;
    end

endmodule

`default_nettype wire

// ==== hw/rv_mem_stage.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_mem_stage import rv_core_pkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    input  ex_mem_t               mem_in,
    input  wire logic             uart_busy,
    output logic      [`XLEN-1:0] mem_fwd,
    output mem_wb_t               mem_out,
    output uart_tx_t              uart_tx
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [`XLEN-1:0] addr;
    logic [AW-1:0]    word_idx;
    logic             hit_tx;
    logic             hit_status;
    logic             tx_write;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] wb_data;

    assign addr       = mem_in.alu_result;
    assign word_idx   = addr[AW+1:2];
    assign hit_tx     = (addr == `UART_TX_ADDR);
    assign hit_status = (addr == `UART_STATUS_ADDR);
    assign tx_write   = mem_in.valid && mem_in.mem_write && hit_tx;

    // MMIO addresses never reach the data memory
    always_ff @(posedge clk) begin
        if (mem_in.valid && mem_in.mem_write && !hit_tx && !hit_status) begin
            dmem[word_idx] <= mem_in.store_data;
        end
    end

    always_comb begin
        load_data = '0;
        if (mem_in.mem_read) begin
            load_data = hit_status ? {{(`XLEN-1){1'b0}}, uart_busy} : dmem[word_idx];
        end
    end

    always_comb begin
        case (mem_in.wb_sel)
            WB_LOAD: wb_data = load_data;
            WB_PC4:  wb_data = mem_in.pc_plus_4;
            default: wb_data = mem_in.alu_result;
        endcase
    end

    assign mem_fwd = wb_data;

    always_comb begin
        mem_out           = '0;
        mem_out.valid     = mem_in.valid;
        mem_out.instr     = mem_in.instr;
        mem_out.reg_write = mem_in.reg_write;
        mem_out.rd        = mem_in.rd;
        mem_out.wb_data   = wb_data;
    end

    // Start is a one-cycle pulse, data holds the last byte sent
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            uart_tx <= '0;
        end else begin
            uart_tx.start <= tx_write;
            if (tx_write) begin
                uart_tx.data <= mem_in.store_data[7:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_core import rv_core_pkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    output logic      [`XLEN-1:0] imem_addr,
    input  wire logic [`XLEN-1:0] imem_data,
    input  wire logic             uart_busy,
    output uart_tx_t              uart_tx,
    output logic                  retire_valid,
    output logic      [31:0]      retire_instr
);

    if_id_t  if_d;
    if_id_t  if_q;
    id_ex_t  id_d;
    id_ex_t  id_q;
    ex_mem_t ex_d;
    ex_mem_t ex_q;
    mem_wb_t mem_d;
    mem_wb_t mem_q;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   stall_fetch;
    logic                   stall_decode;
    logic                   flush_decode;
    logic                   flush_execute;
    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;
    fwd_sel_e               fwd_store;
    logic [`XLEN-1:0]       mem_fwd;

    rv_fetch fetch_i (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall_fetch),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_out      (if_d)
    );

    stage_reg #(.payload_t(if_id_t)) if_id_i (
        .clk   (clk),
        .reset (reset),
        .stall (stall_decode),
        .flush (flush_decode),
        .d     (if_d),
        .q     (if_q)
    );

    rv_decode decode_i (
        .if_in    (if_q),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .id_out   (id_d)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (mem_q)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_i (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (flush_execute),
        .d     (id_d),
        .q     (id_q)
    );

    rv_hazard hazard_i (
        .id_in         (id_d),
        .ex_in         (id_q),
        .mem_in        (ex_q),
        .wb_in         (mem_q),
        .redirect      (redirect),
        .stall_fetch   (stall_fetch),
        .stall_decode  (stall_decode),
        .flush_decode  (flush_decode),
        .flush_execute (flush_execute),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fwd_store     (fwd_store)
    );

    rv_execute execute_i (
        .ex_in       (id_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .fwd_store   (fwd_store),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (mem_q.wb_data),
        .ex_out      (ex_d),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_i (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (ex_d),
        .q     (ex_q)
    );

    rv_mem_stage mem_stage_i (
        .clk       (clk),
        .reset     (reset),
        .mem_in    (ex_q),
        .uart_busy (uart_busy),
        .mem_fwd   (mem_fwd),
        .mem_out   (mem_d),
        .uart_tx   (uart_tx)
    );

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_i (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (mem_d),
        .q     (mem_q)
    );

    // Retirement is the instruction leaving WB
    assign retire_valid = mem_q.valid;
    assign retire_instr = mem_q.instr;

endmodule

`default_nettype wire

// ==== verification/rv_core_tb.sv ====
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_tb import rv_core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 10;
    localparam int HALT_WINDOW  = 50;
    localparam int DRAIN_CYCLES = 20;
    localparam int ROM_WORDS    = 1024;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic             uart_busy;
    uart_tx_t         uart_tx;
    logic             retire_valid;
    logic [31:0]      retire_instr;

    logic [31:0] rom_words  [ROM_WORDS];
    logic        rom_loaded [ROM_WORDS];
    logic [7:0]  exp_bytes  [$];
    logic [31:0] halt_word;
    logic [31:0] first_word;
    int          prog_len;
    bit          vectors_ready;
    bit          done;
    int          check_count;
    int          error_count;
    int          byte_count;
    int          cycle;
    int          last_byte_cycle;
    int          busy_left;

    rv_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .uart_busy    (uart_busy),
        .uart_tx      (uart_tx),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr)
    );

    // Instruction ROM, unmapped addresses read as NOP
    always_comb begin
        imem_data = `NOP_INSTR;
        if (imem_addr[31:12] == '0 && rom_loaded[imem_addr[11:2]]) begin
            imem_data = rom_words[imem_addr[11:2]];
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("t=%0t: %s", $time, what);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors, %0d of %0d bytes received",
                 check_count, error_count, byte_count, exp_bytes.size());
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic load_vectors(output bit ok);
        int          fd;
        string       line;
        logic [31:0] addr;
        logic [31:0] word;
        foreach (rom_loaded[i]) begin
            rom_loaded[i] = 1'b0;
        end
        ok = 1'b0;
        fd = $fopen("verification/rv_core_vectors.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "P %h %h", addr, word) == 2) begin
                    rom_words[addr[11:2]]  = word;
                    rom_loaded[addr[11:2]] = 1'b1;
                    prog_len++;
                    if (addr == `RESET_PC) begin
                        first_word = word;
                    end
                end else if ($sscanf(line, "U %h", word) == 1) begin
                    exp_bytes.push_back(word[7:0]);
                end else if ($sscanf(line, "H %h", word) == 1) begin
                    halt_word = word;
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        bit ok;
        reset           = 1'b1;
        uart_busy       = 1'b0;
        check_count     = 0;
        error_count     = 0;
        byte_count      = 0;
        cycle           = 0;
        last_byte_cycle = 0;
        busy_left       = 0;
        prog_len        = 0;
        halt_word       = '0;
        first_word      = `NOP_INSTR;
        done            = 1'b0;
        vectors_ready   = 1'b0;
        void'($urandom(32'hff01_85a1));
        load_vectors(ok);
        if (!ok) begin
            error_count++;
            $display("Could not open the vector file verification/rv_core_vectors.txt");
            finish_run();
        end else begin
            vectors_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #2;
            reset = 1'b0;
            wait (done);
            // Let any stray start pulse show up
            repeat (DRAIN_CYCLES) @(posedge clk);
            #3;
            check_value("byte_count", byte_count, exp_bytes.size());
            finish_run();
        end
    end

    // Sample 1 ns after the edge, drive uart_busy at 2 ns
    always @(posedge clk) begin
        logic next_busy;
        #1;
        next_busy = uart_busy;
        if (reset) begin
            check_value("uart_tx.start", 32'(uart_tx.start), 0);
            check_value("retire_valid", 32'(retire_valid), 0);
        end else begin
            cycle++;
            if (cycle < 4) begin
                check_value("retire_valid", 32'(retire_valid), 0);
            end
            if (cycle <= 4) begin
                check_value("uart_tx.start", 32'(uart_tx.start), 0);
            end
            // First instruction retires exactly 4 cycles after fetch
            if (cycle == 4) begin
                check_value("retire_valid", 32'(retire_valid), 1);
                check_value("retire_instr", retire_instr, first_word);
            end
            if (retire_valid) begin
                check_true(retire_instr != '0, "a retired instruction reads as zero");
            end
            if (uart_tx.start) begin
                check_true(!uart_busy, "a start pulse came while uart_busy was high");
                if (byte_count < exp_bytes.size()) begin
                    check_value("uart_tx.data", 32'(uart_tx.data),
                                32'(exp_bytes[byte_count]));
                end else begin
                    check_true(1'b0, "a byte was sent beyond the expected list");
                end
                byte_count++;
                if (byte_count == exp_bytes.size()) begin
                    last_byte_cycle = cycle;
                end
                next_busy = 1'b1;
                busy_left = 3 + int'($urandom % 18);
            end else if (busy_left > 0) begin
                busy_left--;
                if (busy_left == 0) begin
                    next_busy = 1'b0;
                end
            end
            if (!done && byte_count >= exp_bytes.size()) begin
                if (retire_valid && retire_instr == halt_word) begin
                    done = 1'b1;
                end else if (cycle - last_byte_cycle >= HALT_WINDOW) begin
                    check_true(1'b0, "the halt word did not retire after the last byte");
                    done = 1'b1;
                end
            end
        end
        #1;
        uart_busy = next_busy;
    end

    initial begin
        int limit;
        wait (vectors_ready);
        limit = (prog_len + 64 * exp_bytes.size()) * 60;
        repeat (limit) @(posedge clk);
        error_count++;
        $display("Watchdog expired after %0d cycles, the program never finished", limit);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verification/rv_core_vectors.txt ====
# P <byte address hex> <instruction hex> | U <expected UART byte hex> | H <halt instruction hex>
# Program: dependent ALU ops, store and reload, branches with wrong-path stores, polled sends
P 00000000 00010437
P 00000004 00500513
P 00000008 00750593
P 0000000c 00a58533
P 00000010 07c000ef
P 00000014 00351513
P 00000018 00f54513
P 0000001c 070000ef
P 00000020 fc000613
P 00000024 40265613
P 00000028 40c58533
P 0000002c 060000ef
P 00000030 05a00693
P 00000034 04d02023
P 00000038 04002703
P 0000003c 00170513
P 00000040 04c000ef
P 00000044 03300793
P 00000048 04f02223
P 0000004c 04402503
P 00000050 03c000ef
P 00000054 00300813
P 00000058 00080463
P 0000005c 04100513
P 00000060 00081663
P 00000064 01042023
P 00000068 01042023
P 0000006c 020000ef
P 00000070 00064663
P 00000074 00c42023
P 00000078 00c42023
P 0000007c 00066463
P 00000080 00150513
P 00000084 008000ef
P 00000088 0000006f
P 0000008c 00442283
P 00000090 fe029ee3
P 00000094 00a42023
P 00000098 00008067
U 11
U 87
U 1c
U 5b
U 33
U 41
U 42
H 0000006f

// ==== rv_core.f ====
+incdir+hw
hw/rv_core_pkg.sv
hw/stage_reg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_hazard.sv
hw/rv_execute.sv
hw/rv_mem_stage.sv
hw/rv_core.sv
verification/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rv_core_tb \
    -f rv_core.f \
    -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
